// ==== Makefile ====
SIM       ?= verilator
SIM_FLAGS ?= --binary --timing --assert -j 0
TOP       ?= tb_wino_output_transform
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := ALL CHECKS PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "^$(PASS_MSG)$$" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== design/wino_adder_tree.sv ====
`default_nettype none

module wino_adder_tree #(
	parameter int WIDTH = 30
) (
	input  wire                     clk,
	input  wire signed [WIDTH-1:0]  i_term0,
	input  wire signed [WIDTH-1:0]  i_term1,
	input  wire signed [WIDTH-1:0]  i_term2,
	input  wire signed [WIDTH-1:0]  i_term3,
	input  wire signed [WIDTH-1:0]  i_term4,
	output logic signed [WIDTH-1:0] o_sum
);

	// Stage 1 holds two pair sums and the odd term
	logic signed [WIDTH-1:0] s1_pair_a;
	logic signed [WIDTH-1:0] s1_pair_b;
	logic signed [WIDTH-1:0] s1_single;

	// Stage 2 holds the four-term sum and the carried odd term
	logic signed [WIDTH-1:0] s2_quad;
	logic signed [WIDTH-1:0] s2_single;

	// All sums wrap at WIDTH bits, callers keep their range inside it
	always_ff @(posedge clk) begin
		s1_pair_a <= i_term0 + i_term1;
		s1_pair_b <= i_term2 + i_term3;
		s1_single <= i_term4;
	end

	always_ff @(posedge clk) begin
		s2_quad   <= s1_pair_a + s1_pair_b;
		s2_single <= s1_single;
	end

	always_ff @(posedge clk) begin
		o_sum <= s2_quad + s2_single;
	end

endmodule

`default_nettype wire

// ==== design/wino_burst_control.sv ====
`default_nettype none

module wino_burst_control #(
	parameter int ADD_LAT = 3
) (
	input  wire  clk,
	input  wire  i_rst_n,
	input  wire  i_valid,
	output logic o_row_shift,
	output logic o_col_shift,
	output logic o_col_first
);

	localparam int CNT_W = $clog2(wino_pkg::TILE_OUT);
	localparam logic [CNT_W-1:0] DRAIN_LAST = CNT_W'(wino_pkg::TILE_OUT - 1);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_COLLECT,
		ST_DRAIN
	} state_t;

	state_t             state;
	state_t             state_nxt;
	logic [ADD_LAT-1:0] vld_dly;
	logic               dly_valid;
	logic [CNT_W-1:0]   drain_cnt;

	// **************************************************
	// Valid delay, lines up with the row transform output
	// **************************************************

	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			vld_dly <= '0;
		end else begin
			vld_dly <= {vld_dly[ADD_LAT-2:0], i_valid};
		end
	end

	assign dly_valid = vld_dly[ADD_LAT-1];

	// **************************************************
	// Burst FSM
	// **************************************************

	always_comb begin
		state_nxt = state;
		case (state)
			ST_IDLE: begin
				if (dly_valid) begin
					state_nxt = ST_COLLECT;
				end
			end
			ST_COLLECT: begin
				// The store holds the whole tile once the delayed valid drops
				if (!dly_valid) begin
					state_nxt = ST_DRAIN;
				end
			end
			ST_DRAIN: begin
				if (drain_cnt == DRAIN_LAST) begin
					state_nxt = ST_IDLE;
				end
			end
			default: begin
				state_nxt = ST_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state     <= ST_IDLE;
			drain_cnt <= '0;
		end else begin
			state <= state_nxt;
			if (state == ST_DRAIN) begin
				drain_cnt <= drain_cnt + 1'b1;
			end else begin
				drain_cnt <= '0;
			end
		end
	end

	assign o_row_shift = dly_valid;
	assign o_col_shift = (state == ST_DRAIN);
	assign o_col_first = o_col_shift && (drain_cnt == '0);

	// **************************************************
	// Burst protocol checks
	// **************************************************

	a_burst_max : assert property (@(posedge clk) disable iff (!i_rst_n)
		dly_valid [*wino_pkg::TILE_IN] |=> !dly_valid);

	a_burst_len : assert property (@(posedge clk) disable iff (!i_rst_n)
		$rose(dly_valid) |-> dly_valid [*wino_pkg::TILE_IN] ##1 !dly_valid);

	// Upstream waits for the drain, there is no back-pressure
	a_no_valid_in_drain : assert property (@(posedge clk) disable iff (!i_rst_n)
		(state == ST_DRAIN) |-> !i_valid);

endmodule

`default_nettype wire

// ==== design/wino_output_transform.sv ====
`default_nettype none

module wino_output_transform #(
	parameter int DATA_W     = wino_pkg::DATA_W,
	parameter int FRAC_SHIFT = 8
) (
	input  wire                 clk,
	input  wire                 i_rst_n,
	input  wire                 i_valid,
	input  wino_pkg::in_row_t   i_row,
	output logic                o_valid,
	output wino_pkg::pix_row_t  o_pix
);

	// **************************************************
	// Internal connections
	// **************************************************

	wino_pkg::mid_row_t mid_row;
	logic               row_shift;
	logic               col_shift;
	logic               col_first;

	// A^T applied to each incoming row, result ADD_LAT cycles later
	wino_row_transform #(
		.WIDTH(DATA_W)
	) i_row_transform (
		.clk  (clk),
		.i_row(i_row),
		.o_row(mid_row)
	);

	wino_burst_control #(
		.ADD_LAT(wino_pkg::ADD_LAT)
	) i_burst_control (
		.clk        (clk),
		.i_rst_n    (i_rst_n),
		.i_valid    (i_valid),
		.o_row_shift(row_shift),
		.o_col_shift(col_shift),
		.o_col_first(col_first)
	);

	// Each o_valid beat j holds Y[0..3][j] of Y = A^T*M*A
	wino_tile_store #(
		.WIDTH     (DATA_W),
		.FRAC_SHIFT(FRAC_SHIFT)
	) i_tile_store (
		.clk        (clk),
		.i_rst_n    (i_rst_n),
		.i_row      (mid_row),
		.i_row_shift(row_shift),
		.i_col_shift(col_shift),
		.i_col_first(col_first),
		.o_pix      (o_pix),
		.o_valid    (o_valid)
	);

endmodule

`default_nettype wire

// ==== design/wino_pkg.sv ====
`default_nettype none

package wino_pkg;

	// **************************************************
	// Widths and tile geometry
	// **************************************************

	// Transform-domain value and every intermediate sum
	localparam int DATA_W = 30;

	// Rescaled output pixel
	localparam int OUT_W = 16;

	// Values per input row and rows per burst
	localparam int TILE_IN = 6;

	// Values per output row and output rows per tile
	localparam int TILE_OUT = 4;

	// Pipeline depth of the five-term adder tree
	localparam int ADD_LAT = 3;

	// **************************************************
	// Row types
	// **************************************************

	// One input row, also used for a column drained from the store
	typedef struct packed {
		logic signed [DATA_W-1:0] m0;
		logic signed [DATA_W-1:0] m1;
		logic signed [DATA_W-1:0] m2;
		logic signed [DATA_W-1:0] m3;
		logic signed [DATA_W-1:0] m4;
		logic signed [DATA_W-1:0] m5;
	} in_row_t;

	// Four values after one pass of A^T
	typedef struct packed {
		logic signed [DATA_W-1:0] v0;
		logic signed [DATA_W-1:0] v1;
		logic signed [DATA_W-1:0] v2;
		logic signed [DATA_W-1:0] v3;
	} mid_row_t;

	typedef struct packed {
		logic [OUT_W-1:0] p0;
		logic [OUT_W-1:0] p1;
		logic [OUT_W-1:0] p2;
		logic [OUT_W-1:0] p3;
	} pix_row_t;

endpackage

`default_nettype wire

// ==== design/wino_row_transform.sv ====
`default_nettype none

module wino_row_transform #(
	parameter int WIDTH = 30
) (
	input  wire                 clk,
	input  wino_pkg::in_row_t   i_row,
	output wino_pkg::mid_row_t  o_row
);

	// Scaled and negated terms of A^T, coefficients (1, 1, 4, 4) on row 2
	logic signed [WIDTH-1:0] neg_m2;
	logic signed [WIDTH-1:0] m3_x2;
	logic signed [WIDTH-1:0] m3_x4;
	logic signed [WIDTH-1:0] m3_x8;
	logic signed [WIDTH-1:0] m4_x4;
	logic signed [WIDTH-1:0] neg_m4_x2;
	logic signed [WIDTH-1:0] neg_m4_x8;
	logic signed [WIDTH-1:0] sum0;
	logic signed [WIDTH-1:0] sum1;
	logic signed [WIDTH-1:0] sum2;
	logic signed [WIDTH-1:0] sum3;

	assign neg_m2    = -i_row.m2;
	assign m3_x2     = i_row.m3 <<< 1;
	assign m3_x4     = i_row.m3 <<< 2;
	assign m3_x8     = i_row.m3 <<< 3;
	assign m4_x4     = i_row.m4 <<< 2;
	assign neg_m4_x2 = -(i_row.m4 <<< 1);
	assign neg_m4_x8 = -(i_row.m4 <<< 3);

	// v0 = m0 + m1 + m2 + m3 + m4
	wino_adder_tree #(.WIDTH(WIDTH)) i_tree0 (
		.clk(clk), .i_term0(i_row.m0), .i_term1(i_row.m1), .i_term2(i_row.m2),
		.i_term3(i_row.m3), .i_term4(i_row.m4), .o_sum(sum0)
	);

	// v1 = m1 - m2 + 2*m3 - 2*m4
	wino_adder_tree #(.WIDTH(WIDTH)) i_tree1 (
		.clk(clk), .i_term0(i_row.m1), .i_term1(neg_m2), .i_term2(m3_x2),
		.i_term3(neg_m4_x2), .i_term4('0), .o_sum(sum1)
	);

	// v2 = m1 + m2 + 4*m3 + 4*m4
	wino_adder_tree #(.WIDTH(WIDTH)) i_tree2 (
		.clk(clk), .i_term0(i_row.m1), .i_term1(i_row.m2), .i_term2(m3_x4),
		.i_term3(m4_x4), .i_term4('0), .o_sum(sum2)
	);

	// v3 = m1 - m2 + 8*m3 - 8*m4 + m5
	wino_adder_tree #(.WIDTH(WIDTH)) i_tree3 (
		.clk(clk), .i_term0(i_row.m1), .i_term1(neg_m2), .i_term2(m3_x8),
		.i_term3(neg_m4_x8), .i_term4(i_row.m5), .o_sum(sum3)
	);

	assign o_row = '{v0: sum0, v1: sum1, v2: sum2, v3: sum3};

endmodule

`default_nettype wire

// ==== design/wino_tile_store.sv ====
`default_nettype none

module wino_tile_store #(
	parameter int WIDTH      = 30,
	parameter int FRAC_SHIFT = 8
) (
	input  wire                 clk,
	input  wire                 i_rst_n,
	input  wino_pkg::mid_row_t  i_row,
	input  wire                 i_row_shift,
	input  wire                 i_col_shift,
	input  wire                 i_col_first,
	output wino_pkg::pix_row_t  o_pix,
	output logic                o_valid
);

	localparam int ROW_CNT_W = $clog2(wino_pkg::TILE_IN + 1);

	wino_pkg::mid_row_t          rows [wino_pkg::TILE_IN];
	wino_pkg::in_row_t           col;
	logic signed [WIDTH-1:0]     neg_m2;
	logic signed [WIDTH-1:0]     m3_x2;
	logic signed [WIDTH-1:0]     m3_x4;
	logic signed [WIDTH-1:0]     m3_x8;
	logic signed [WIDTH-1:0]     m4_x4;
	logic signed [WIDTH-1:0]     neg_m4_x2;
	logic signed [WIDTH-1:0]     neg_m4_x8;
	logic signed [WIDTH-1:0]     sum0;
	logic signed [WIDTH-1:0]     sum1;
	logic signed [WIDTH-1:0]     sum2;
	logic signed [WIDTH-1:0]     sum3;
	logic [wino_pkg::ADD_LAT-1:0] col_vld_dly;
	logic [ROW_CNT_W-1:0]        row_cnt;

	// Negative values clip to zero, the rest drop FRAC_SHIFT fraction bits
	function automatic logic [wino_pkg::OUT_W-1:0] quantize(input logic signed [WIDTH-1:0] value);
		if (value[WIDTH-1]) begin
			return '0;
		end
		return value[FRAC_SHIFT +: wino_pkg::OUT_W];
	endfunction

	// **************************************************
	// Row array and column rotation
	// **************************************************

	// Row 0 is the oldest row, lane 0 of every row forms the drained column
	always_ff @(posedge clk) begin
		if (i_row_shift) begin
			for (int r = 0; r < wino_pkg::TILE_IN - 1; r++) begin
				rows[r] <= rows[r+1];
			end
			rows[wino_pkg::TILE_IN-1] <= i_row;
		end else if (i_col_shift) begin
			for (int r = 0; r < wino_pkg::TILE_IN; r++) begin
				rows[r] <= '{v0: rows[r].v1, v1: rows[r].v2, v2: rows[r].v3, v3: rows[r].v0};
			end
		end
	end

	assign col = '{m0: rows[0].v0, m1: rows[1].v0, m2: rows[2].v0,
		m3: rows[3].v0, m4: rows[4].v0, m5: rows[5].v0};

	// Rows loaded since the last drain started
	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			row_cnt <= '0;
		end else if (i_col_first) begin
			row_cnt <= '0;
		end else if (i_row_shift) begin
			row_cnt <= row_cnt + 1'b1;
		end
	end

	// **************************************************
	// Column transform
	// **************************************************

	assign neg_m2    = -col.m2;
	assign m3_x2     = col.m3 <<< 1;
	assign m3_x4     = col.m3 <<< 2;
	assign m3_x8     = col.m3 <<< 3;
	assign m4_x4     = col.m4 <<< 2;
	assign neg_m4_x2 = -(col.m4 <<< 1);
	assign neg_m4_x8 = -(col.m4 <<< 3);

	wino_adder_tree #(.WIDTH(WIDTH)) i_tree0 (
		.clk(clk), .i_term0(col.m0), .i_term1(col.m1), .i_term2(col.m2),
		.i_term3(col.m3), .i_term4(col.m4), .o_sum(sum0)
	);

	wino_adder_tree #(.WIDTH(WIDTH)) i_tree1 (
		.clk(clk), .i_term0(col.m1), .i_term1(neg_m2), .i_term2(m3_x2),
		.i_term3(neg_m4_x2), .i_term4('0), .o_sum(sum1)
	);

	wino_adder_tree #(.WIDTH(WIDTH)) i_tree2 (
		.clk(clk), .i_term0(col.m1), .i_term1(col.m2), .i_term2(m3_x4),
		.i_term3(m4_x4), .i_term4('0), .o_sum(sum2)
	);

	wino_adder_tree #(.WIDTH(WIDTH)) i_tree3 (
		.clk(clk), .i_term0(col.m1), .i_term1(neg_m2), .i_term2(m3_x8),
		.i_term3(neg_m4_x8), .i_term4(col.m5), .o_sum(sum3)
	);

	// **************************************************
	// Valid alignment and output register
	// **************************************************

	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			col_vld_dly <= '0;
			o_valid     <= 1'b0;
		end else begin
			col_vld_dly <= {col_vld_dly[wino_pkg::ADD_LAT-2:0], i_col_shift};
			o_valid     <= col_vld_dly[wino_pkg::ADD_LAT-1];
		end
	end

	// Beat j carries lane j of the stored rows after the column transform
	always_ff @(posedge clk) begin
		o_pix <= '{p0: quantize(sum0), p1: quantize(sum1),
			p2: quantize(sum2), p3: quantize(sum3)};
	end

	a_valid_max : assert property (@(posedge clk) disable iff (!i_rst_n)
		o_valid [*wino_pkg::TILE_OUT] |=> !o_valid);

	a_shift_excl : assert property (@(posedge clk) disable iff (!i_rst_n)
		!(i_row_shift && i_col_shift));

	// The controller must not start a drain before the tile is complete
	a_full_tile : assert property (@(posedge clk) disable iff (!i_rst_n)
		i_col_first |-> (row_cnt == ROW_CNT_W'(wino_pkg::TILE_IN)));

endmodule

`default_nettype wire

// ==== tb.f ====
design/wino_pkg.sv
design/wino_adder_tree.sv
design/wino_row_transform.sv
design/wino_burst_control.sv
design/wino_tile_store.sv
design/wino_output_transform.sv
test/tb_clock_gen.sv
test/tb_wino_output_transform.sv

// ==== test/tb_clock_gen.sv ====
`default_nettype none

module tb_clock_gen #(
	parameter int PERIOD     = 10,
	parameter int RST_CYCLES = 4
) (
	output logic o_clk,
	output logic o_rst_n
);

	initial begin
		o_clk = 1'b0;
		forever begin
			#(PERIOD / 2) o_clk = ~o_clk;
		end
	end

	// Reset is released on a falling edge, away from the sampling edge
	initial begin
		o_rst_n = 1'b0;
		repeat (RST_CYCLES) @(posedge o_clk);
		@(negedge o_clk);
		o_rst_n = 1'b1;
	end

endmodule

`default_nettype wire

// ==== test/tb_wino_output_transform.sv ====
`default_nettype none

module tb_wino_output_transform;

	localparam int FRAC_SHIFT    = 8;
	localparam int NUM_TILES     = 200;
	localparam int TILE_CYCLES   = 40;
	localparam int MARGIN_CYCLES = 200;
	localparam int DW            = wino_pkg::DATA_W;
	localparam int OW            = wino_pkg::OUT_W;
	localparam int N_IN          = wino_pkg::TILE_IN;
	localparam int N_OUT         = wino_pkg::TILE_OUT;

	// Rows of A^T for F(4,3) with row 2 as (1, 1, 4, 4)
	localparam int AT [4][6] = '{
		'{1, 1, 1, 1, 1, 0},
		'{0, 1, -1, 2, -2, 0},
		'{0, 1, 1, 4, 4, 0},
		'{0, 1, -1, 8, -8, 1}
	};

	// Sign pattern that makes every term of output (3,3) add up
	localparam int SIGN3 [6] = '{1, 1, -1, 1, -1, 1};

	logic               clk;
	logic               rst_n;
	logic               in_valid;
	wino_pkg::in_row_t  in_row;
	logic               out_valid;
	wino_pkg::pix_row_t out_pix;

	longint             tile [N_IN][N_IN];
	wino_pkg::pix_row_t exp_q [$];
	wino_pkg::pix_row_t expected_pix;
	int                 rows_checked;
	int                 run_len;
	int                 n_clipped;
	int                 n_high;

	tb_clock_gen #(
		.PERIOD    (10),
		.RST_CYCLES(4)
	) i_clock_gen (
		.o_clk  (clk),
		.o_rst_n(rst_n)
	);

	wino_output_transform #(
		.DATA_W    (DW),
		.FRAC_SHIFT(FRAC_SHIFT)
	) i_dut (
		.clk    (clk),
		.i_rst_n(rst_n),
		.i_valid(in_valid),
		.i_row  (in_row),
		.o_valid(out_valid),
		.o_pix  (out_pix)
	);

	task automatic abort_run();
		$display("CHECKS FAILED");
		$fatal(1, "Run stopped at the first failure");
	endtask

	function automatic logic [wino_pkg::OUT_W-1:0] rectify(input longint value);
		if (value < 0) begin
			return '0;
		end
		return OW'(value >>> FRAC_SHIFT);
	endfunction

	function automatic longint draw_value(input int kind, input int r, input int c);
		logic [15:0] raw;
		longint      mag;
		raw = 16'($urandom);
		case (kind)
			1: begin
				// Every input lies at or below -16384
				return -longint'($urandom_range(32768, 16384));
			end
			2: begin
				mag = longint'($urandom_range(32767, 24576));
				return SIGN3[r] * SIGN3[c] * mag;
			end
			default: begin
				return longint'($signed(raw));
			end
		endcase
	endfunction

	// **************************************************
	// Reference model of Y = A^T * M * A in integers
	// **************************************************

	task automatic expect_tile();
		longint             x [N_IN][N_OUT];
		longint             y [N_OUT][N_OUT];
		wino_pkg::pix_row_t beat;
		for (int r = 0; r < N_IN; r++) begin
			for (int k = 0; k < N_OUT; k++) begin
				x[r][k] = 0;
				for (int c = 0; c < N_IN; c++) begin
					x[r][k] += AT[k][c] * tile[r][c];
				end
			end
		end
		for (int i = 0; i < N_OUT; i++) begin
			for (int j = 0; j < N_OUT; j++) begin
				y[i][j] = 0;
				for (int r = 0; r < N_IN; r++) begin
					y[i][j] += AT[i][r] * x[r][j];
				end
				if (y[i][j] < 0) begin
					n_clipped++;
				end
				if (y[i][j] >= (longint'(1) <<< (FRAC_SHIFT + 15))) begin
					n_high++;
				end
			end
		end
		// Beat j carries column j of Y with the top row in p0
		for (int j = 0; j < N_OUT; j++) begin
			beat = '{p0: rectify(y[0][j]), p1: rectify(y[1][j]),
				p2: rectify(y[2][j]), p3: rectify(y[3][j])};
			exp_q.push_back(beat);
		end
	endtask

	// Called on a falling edge and returns on the falling edge after the burst
	task automatic send_tile(input int kind);
		for (int r = 0; r < N_IN; r++) begin
			for (int c = 0; c < N_IN; c++) begin
				tile[r][c] = draw_value(kind, r, c);
			end
		end
		expect_tile();
		for (int r = 0; r < N_IN; r++) begin
			in_valid = 1'b1;
			in_row = '{
				m0: DW'(tile[r][0]),
				m1: DW'(tile[r][1]),
				m2: DW'(tile[r][2]),
				m3: DW'(tile[r][3]),
				m4: DW'(tile[r][4]),
				m5: DW'(tile[r][5])
			};
			@(negedge clk);
		end
		in_valid = 1'b0;
		in_row = '0;
	endtask

	// The first output beat of a tile shows up as the drain state is left
	task automatic wait_first_beat();
		do begin
			@(negedge clk);
		end while (!out_valid);
	endtask

	// **************************************************
	// Output monitor
	// **************************************************

	always @(negedge clk) begin
		if (out_valid) begin
			assert (exp_q.size() != 0) else begin
				$display("An output beat appeared with no tile sent to produce it");
				abort_run();
			end
			expected_pix = exp_q.pop_front();
			assert (out_pix == expected_pix) else begin
				$display("ERROR: o_pix = %h, expected %h", out_pix, expected_pix);
				abort_run();
			end
			rows_checked++;
			run_len++;
			assert (run_len <= N_OUT) else begin
				$display("ERROR: o_valid run length = %h, expected at most %h", run_len, N_OUT);
				abort_run();
			end
		end else if (run_len != 0) begin
			assert (run_len == N_OUT) else begin
				$display("ERROR: o_valid run length = %h, expected %h", run_len, N_OUT);
				abort_run();
			end
			run_len = 0;
		end
	end

	initial begin
		repeat (NUM_TILES * TILE_CYCLES + MARGIN_CYCLES) @(posedge clk);
		$display("Watchdog expired before every tile was checked");
		abort_run();
	end

	// **************************************************
	// Stimulus
	// **************************************************

	initial begin
		int gap;
		void'($urandom(32'h2965));
		in_valid     = 1'b0;
		in_row       = '0;
		rows_checked = 0;
		run_len      = 0;
		n_clipped    = 0;
		n_high       = 0;

		@(negedge clk);
		assert (!out_valid) else begin
			$display("ERROR: o_valid = %h during reset, expected 0", out_valid);
			abort_run();
		end
		wait (rst_n === 1'b1);
		@(negedge clk);
		repeat (10) begin
			assert (!out_valid) else begin
				$display("ERROR: o_valid = %h with no burst sent, expected 0", out_valid);
				abort_run();
			end
			@(negedge clk);
		end

		// Kinds 0 and 3 are full range while 1 is negative and 2 is large positive
		for (int t = 0; t < NUM_TILES; t++) begin
			send_tile(t % 4);
			wait_first_beat();
			gap = int'($urandom_range(5, 0));
			repeat (gap) @(negedge clk);
		end

		while (rows_checked < NUM_TILES * N_OUT) begin
			@(negedge clk);
		end
		repeat (10) @(negedge clk);

		assert (exp_q.size() == 0) else begin
			$display("Expected rows were left over after the last tile");
			abort_run();
		end
		assert (run_len == 0) else begin
			$display("The last o_valid run did not close");
			abort_run();
		end
		assert (n_clipped > 0 && n_high > 0) else begin
			$display("The tiles never reached a clipped or a high pixel");
			abort_run();
		end

		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

`default_nettype wire
